// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

////////////////////////////////////////
// Widths and credit counts
////////////////////////////////////////
`define DATA_WIDTH 32 // Data word size
`define REG_ADDR_WIDTH 5 // 32 registers
`define MEM_ADDR_WIDTH 6 // 64 memory words
`define RETIRE_CREDITS 4 // Granted by the consumer after reset
`define CREDIT_WIDTH 3 // Holds 0 to RETIRE_CREDITS

////////////////////////////////////////
// Opcodes
////////////////////////////////////////
`define OP_RTYPE 6'd0
`define OP_LW 6'd35
`define OP_LWU 6'd39
`define OP_LB 6'd32
`define OP_LBU 6'd36
`define OP_LH 6'd33
`define OP_LHU 6'd37
`define OP_SW 6'd43
`define OP_SB 6'd40
`define OP_SH 6'd41
`define OP_BEQ 6'd4
`define OP_BNE 6'd5
`define OP_ADDI 6'd8
`define OP_SLTI 6'd10
`define OP_ANDI 6'd12
`define OP_ORI 6'd13
`define OP_LUI 6'd15

// R-type function field
`define FN_ADD 6'd32
`define FN_SUB 6'd34
`define FN_AND 6'd36
`define FN_OR 6'd37
`define FN_SLT 6'd42

// Load size codes
`define LD_WORD 3'd0
`define LD_WORD_U 3'd1
`define LD_BYTE 3'd2
`define LD_BYTE_U 3'd3
`define LD_HALF 3'd4
`define LD_HALF_U 3'd5

// Store size codes
`define ST_WORD 2'd0
`define ST_BYTE 2'd1
`define ST_HALF 2'd2

// ALU operation class
`define ALU_MEM 2'd0
`define ALU_BRANCH 2'd1
`define ALU_RTYPE 2'd2
`define ALU_IMM 2'd3

`endif

// File: logic/corePkg.sv
`include "core_defs.svh"

package corePkg;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////
	typedef logic [`DATA_WIDTH-1:0] word_t; // Data word
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t; // Register index
	typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr_t; // Memory word index
	typedef logic [5:0] opcode_t; // Bits 31..26
	typedef logic [5:0] funct_t; // Bits 5..0
	typedef logic [1:0] aluClass_t;
	typedef logic [2:0] loadSize_t;
	typedef logic [1:0] storeSize_t;
	typedef logic [`CREDIT_WIDTH-1:0] credit_t;

	// Phases of one instruction
	typedef enum logic [2:0]
	{
		Idle,
		Read,
		Execute,
		Memory,
		Retire
	} seqState_t;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////
	typedef struct packed
	{
		logic regDst; // Rd when set, else Rt
		logic aluSrc; // Immediate as operand B
		logic memToReg; // Write back load data
		logic memWrite;
		logic regWrite;
		logic branch;
		logic branchOnEqual; // BEQ when set, BNE otherwise
		aluClass_t aluClass;
		loadSize_t loadSize;
		storeSize_t storeSize;
		funct_t funct; // Function field, or opcode for non R-type
	} ctrl_t;

	typedef struct packed
	{
		regAddr_t dest;
		word_t value;
		logic regWrite;
		logic branchTaken;
	} retire_t;

endpackage

// File: logic/controlUnit.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module controlUnit
(
	input corePkg::opcode_t opcode,
	input corePkg::funct_t funct,
	output corePkg::ctrl_t ctrl
);
	import corePkg::*;

	always_comb
	begin
		ctrl = ctrl_t'(0); // Unknown opcodes fall out as no-op immediates
		ctrl.aluSrc = 1'b1;
		ctrl.aluClass = `ALU_IMM;
		ctrl.funct = opcode; // Opcode selects the immediate operation
		case (opcode)
			`OP_RTYPE:
			begin
				ctrl.regDst = 1'b1; // Write Rd
				ctrl.aluSrc = 1'b0; // Operand B from Rt
				ctrl.regWrite = 1'b1;
				ctrl.aluClass = `ALU_RTYPE;
				ctrl.funct = funct;
			end
			`OP_LW, `OP_LWU, `OP_LB, `OP_LBU, `OP_LH, `OP_LHU:
			begin
				ctrl.memToReg = 1'b1; // Load data to Rt
				ctrl.regWrite = 1'b1;
				ctrl.aluClass = `ALU_MEM; // Base plus offset
				case (opcode)
					`OP_LWU: ctrl.loadSize = `LD_WORD_U;
					`OP_LB: ctrl.loadSize = `LD_BYTE;
					`OP_LBU: ctrl.loadSize = `LD_BYTE_U;
					`OP_LH: ctrl.loadSize = `LD_HALF;
					`OP_LHU: ctrl.loadSize = `LD_HALF_U;
					default: ctrl.loadSize = `LD_WORD;
				endcase
			end
			`OP_SW, `OP_SB, `OP_SH:
			begin
				ctrl.memWrite = 1'b1; // Rt goes to memory
				ctrl.aluClass = `ALU_MEM;
				case (opcode)
					`OP_SB: ctrl.storeSize = `ST_BYTE;
					`OP_SH: ctrl.storeSize = `ST_HALF;
					default: ctrl.storeSize = `ST_WORD;
				endcase
			end
			`OP_BEQ, `OP_BNE:
			begin
				ctrl.aluSrc = 1'b0; // Compare Rs with Rt
				ctrl.branch = 1'b1;
				ctrl.branchOnEqual = (opcode == `OP_BEQ);
				ctrl.aluClass = `ALU_BRANCH;
			end
			`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI:
				ctrl.regWrite = 1'b1; // Result to Rt
			default:
				ctrl.regWrite = 1'b0;
		endcase
	end

endmodule

// File: logic/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer
(
	input logic clk,
	input logic reset,
	input logic bufferFull, // Instruction waiting in the buffer
	input logic hasCredit, // Retire credit available
	output corePkg::seqState_t state,
	output logic instrCredit,
	output logic loadInstr,
	output logic memStrobe,
	output logic retireStrobe
);
	import corePkg::*;

	seqState_t nextState;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= Idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
				if (bufferFull)
					nextState = Read;
			Read:
				nextState = Execute; // Register file outputs settle
			Execute:
				nextState = Memory; // Result register captures the ALU
			Memory:
				nextState = Retire;
			Retire:
				if (hasCredit)
					nextState = Idle; // Otherwise stall here
			default:
				nextState = Idle;
		endcase
	end

	assign loadInstr = (state == Idle) && bufferFull; // Copy buffer to working register
	assign instrCredit = loadInstr; // Buffer is free again
	assign memStrobe = (state == Memory);
	assign retireStrobe = (state == Retire) && hasCredit;

endmodule

// File: logic/creditCounter.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module creditCounter
(
	input logic clk,
	input logic reset,
	input logic spend, // One record sent
	input logic grant, // One credit returned
	output logic hasCredit
);
	import corePkg::*;

	credit_t count;

	always_ff @(posedge clk)
	begin
		if (reset)
			count <= credit_t'(`RETIRE_CREDITS);
		else if (spend && !grant)
			count <= count - 1'b1;
		else if (grant && !spend)
			count <= count + 1'b1; // Both together leave it unchanged
	end

	assign hasCredit = (count != '0);

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module registerFile
(
	input logic clk,
	input logic reset,
	input corePkg::regAddr_t readA,
	input corePkg::regAddr_t readB,
	input corePkg::regAddr_t writeAddr,
	input logic writeEnable,
	input corePkg::word_t writeData,
	output corePkg::word_t dataA,
	output corePkg::word_t dataB
);
	import corePkg::*;

	word_t regs [0:(1 << `REG_ADDR_WIDTH)-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
				regs[i] <= '0;
		end
		else if (writeEnable && (writeAddr != regAddr_t'(0)))
			regs[writeAddr] <= writeData; // Register zero stays zero
	end

	assign dataA = regs[readA]; // Asynchronous reads
	assign dataB = regs[readB];

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module alu
(
	input corePkg::ctrl_t ctrl,
	input corePkg::word_t operandA,
	input corePkg::word_t operandB,
	output corePkg::word_t result,
	output logic branchTaken
);
	import corePkg::*;

	word_t sum;
	word_t zeroExtB; // Logical immediates use zero extension
	logic lessThan;
	logic equal;

	assign sum = operandA + operandB;
	assign zeroExtB = {16'h0000, operandB[15:0]};
	assign lessThan = ($signed(operandA) < $signed(operandB)); // Signed compare
	assign equal = (operandA == operandB);

	always_comb
	begin
		result = '0;
		case (ctrl.aluClass)
			`ALU_MEM:
				result = sum; // Byte address
			`ALU_BRANCH:
				result = operandA - operandB; // Zero when equal
			`ALU_RTYPE:
				case (ctrl.funct)
					`FN_ADD: result = sum;
					`FN_SUB: result = operandA - operandB;
					`FN_AND: result = operandA & operandB;
					`FN_OR: result = operandA | operandB;
					`FN_SLT: result = word_t'(lessThan);
					default: result = '0;
				endcase
			default:
				case (ctrl.funct) // Immediate class keyed by opcode
					`OP_ADDI: result = sum;
					`OP_SLTI: result = word_t'(lessThan);
					`OP_ANDI: result = operandA & zeroExtB;
					`OP_ORI: result = operandA | zeroExtB;
					`OP_LUI: result = {operandB[15:0], 16'h0000};
					default: result = '0;
				endcase
		endcase
	end

	assign branchTaken = ctrl.branch && (ctrl.branchOnEqual ? equal : !equal);

endmodule

// File: logic/dataMemory.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module dataMemory
(
	input logic clk,
	input logic reset,
	input corePkg::word_t address, // Byte address
	input corePkg::word_t storeData,
	input corePkg::ctrl_t ctrl,
	input logic strobe, // Memory phase
	output corePkg::word_t loadData
);
	import corePkg::*;

	word_t mem [0:(1 << `MEM_ADDR_WIDTH)-1];
	memAddr_t index;
	logic [4:0] byteShift; // Bit offset of the byte lane
	logic [4:0] halfShift; // Bit offset of the half lane
	word_t memWord;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign index = address[`MEM_ADDR_WIDTH+1:2]; // Byte address divided by four
	assign byteShift = {address[1:0], 3'b000};
	assign halfShift = {address[1], 4'b0000};

	////////////////////////////////////////
	// Store merge
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < (1 << `MEM_ADDR_WIDTH); i++)
				mem[i] <= '0;
		end
		else if (strobe && ctrl.memWrite)
		begin
			case (ctrl.storeSize)
				`ST_BYTE: mem[index][byteShift +: 8] <= storeData[7:0]; // Other lanes kept
				`ST_HALF: mem[index][halfShift +: 16] <= storeData[15:0];
				default: mem[index] <= storeData;
			endcase
		end
	end

	////////////////////////////////////////
	// Load extraction
	////////////////////////////////////////
	assign memWord = mem[index];
	assign loadByte = memWord[byteShift +: 8];
	assign loadHalf = memWord[halfShift +: 16];

	always_comb
	begin
		case (ctrl.loadSize)
			`LD_BYTE: loadData = {{24{loadByte[7]}}, loadByte}; // Sign extend
			`LD_BYTE_U: loadData = {24'h000000, loadByte};
			`LD_HALF: loadData = {{16{loadHalf[15]}}, loadHalf};
			`LD_HALF_U: loadData = {16'h0000, loadHalf};
			default: loadData = memWord; // LW and LWU alike on 32 bits
		endcase
	end

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/1ps

module mipsCore
(
	input logic clk,
	input logic reset,
	input logic instrValid, // Producer spends its credit
	input corePkg::word_t instr,
	input logic retireCredit, // Consumer returns a credit
	output logic instrCredit,
	output logic retireValid,
	output corePkg::retire_t retire
);
	import corePkg::*;

	word_t instrBuf; // One-entry buffer
	logic bufferFull;
	word_t instrReg; // Working instruction
	word_t resultReg; // Execute result
	logic takenReg;
	ctrl_t ctrl;
	seqState_t state;
	logic loadInstr;
	logic memStrobe;
	logic retireStrobe;
	logic hasCredit;
	regAddr_t writeAddr;
	word_t dataA;
	word_t dataB;
	word_t immExt;
	word_t operandB;
	word_t aluResult;
	logic branchTaken;
	word_t loadData;
	word_t writeValue;

	////////////////////////////////////////
	// Instruction buffer and registers
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			bufferFull <= 1'b0;
		else if (instrValid)
			bufferFull <= 1'b1;
		else if (loadInstr)
			bufferFull <= 1'b0; // Moved to the working register
	end

	always_ff @(posedge clk)
	begin
		if (instrValid)
			instrBuf <= instr;
		if (loadInstr)
			instrReg <= instrBuf;
		if (state == Execute)
		begin
			resultReg <= aluResult;
			takenReg <= branchTaken;
		end
	end

	controlUnit uControl (.opcode(instrReg[31:26]), .funct(instrReg[5:0]), .ctrl(ctrl));

	cycleSequencer uSequencer
	(
		.clk(clk),
		.reset(reset),
		.bufferFull(bufferFull),
		.hasCredit(hasCredit),
		.state(state),
		.instrCredit(instrCredit),
		.loadInstr(loadInstr),
		.memStrobe(memStrobe),
		.retireStrobe(retireStrobe)
	);

	creditCounter uCredits
	(
		.clk(clk),
		.reset(reset),
		.spend(retireStrobe),
		.grant(retireCredit),
		.hasCredit(hasCredit)
	);

	assign writeAddr = ctrl.regDst ? instrReg[15:11] : instrReg[20:16]; // Rd or Rt

	registerFile uRegs
	(
		.clk(clk),
		.reset(reset),
		.readA(instrReg[25:21]), // Rs
		.readB(instrReg[20:16]), // Rt
		.writeAddr(writeAddr),
		.writeEnable(retireStrobe && ctrl.regWrite),
		.writeData(writeValue),
		.dataA(dataA),
		.dataB(dataB)
	);

	assign immExt = {{16{instrReg[15]}}, instrReg[15:0]}; // Sign extended immediate
	assign operandB = ctrl.aluSrc ? immExt : dataB;

	alu uAlu
	(
		.ctrl(ctrl),
		.operandA(dataA),
		.operandB(operandB),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	dataMemory uMemory
	(
		.clk(clk),
		.reset(reset),
		.address(resultReg),
		.storeData(dataB),
		.ctrl(ctrl),
		.strobe(memStrobe),
		.loadData(loadData)
	);

	////////////////////////////////////////
	// Writeback and retire record
	////////////////////////////////////////
	assign writeValue = ctrl.memToReg ? loadData : resultReg;
	assign retireValid = retireStrobe; // One record per spent credit

	always_comb
	begin
		retire.dest = writeAddr;
		retire.value = writeValue;
		retire.regWrite = ctrl.regWrite;
		retire.branchTaken = takenReg;
	end

endmodule

// File: dv/mipsCore_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module mipsCore_tb;
	import corePkg::*;

	localparam int MaxLines = 64; // Room for the program
	localparam int CreditHold = `RETIRE_CREDITS * 15; // No credits back before this, core runs dry

	logic clk;
	logic reset;
	logic instrValid;
	word_t instr;
	logic retireCredit;
	logic instrCredit;
	logic retireValid;
	retire_t retire;

	word_t progInstr [0:MaxLines-1]; // Instruction words in program order
	retire_t progExpect [0:MaxLines-1]; // Expected retire record per instruction
	int lineCount;
	int sent; // Instructions pushed so far
	int producerCredits; // Producer holds one after reset
	int retired; // Records seen by the consumer
	int outstanding; // Records not yet credited back
	int cycleCount;
	int cycleLimit;
	int mismatches;
	int otherErrors;
	int creditDue [$]; // Cycle at which each credit goes back
	logic [31:0] lcgState;

	mipsCore DUT
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.retireCredit(retireCredit),
		.instrCredit(instrCredit),
		.retireValid(retireValid),
		.retire(retire)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] current);
		return current * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////
	task automatic loadProgram();
		int fd;
		int got;
		string textLine;
		logic [31:0] word;
		logic [31:0] dest;
		logic [31:0] value;
		logic [31:0] wr;
		logic [31:0] taken;
		lineCount = 0;
		fd = $fopen("dv/programStim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file dv/programStim.txt");
			otherErrors++;
		end
		else
		begin
			while (!$feof(fd) && lineCount < MaxLines)
			begin
				textLine = "";
				got = $fgets(textLine, fd);
				if (textLine.len() > 1 && textLine.substr(0, 1) != "//") // Skip column notes
				begin
					got = $sscanf(textLine, "%h %h %h %h %h", word, dest, value, wr, taken);
					if (got == 5)
					begin
						progInstr[lineCount] = word;
						progExpect[lineCount].dest = dest[`REG_ADDR_WIDTH-1:0];
						progExpect[lineCount].value = value;
						progExpect[lineCount].regWrite = wr[0];
						progExpect[lineCount].branchTaken = taken[0];
						lineCount++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] want, input int index);
		assert (got == want)
		else
		begin
			$display("Mismatch %s in record %0d: got %h, expected %h", name, index, got, want);
			mismatches++;
		end
	endtask

	task automatic checkRecord(input retire_t got);
		int delay;
		outstanding++;
		assert (outstanding <= `RETIRE_CREDITS)
		else
		begin
			$display("Consumer holds %0d records but granted only %0d credits",
				outstanding, `RETIRE_CREDITS);
			otherErrors++;
		end
		lcgState = lcgNext(lcgState);
		delay = int'(lcgState[18:16]); // 0 to 7 cycles
		creditDue.push_back(cycleCount + delay);
		assert (retired < lineCount)
		else
		begin
			$display("Retire record %0d arrived after the last instruction", retired);
			otherErrors++;
		end
		if (retired < lineCount)
		begin
			compareField("dest", got.dest, progExpect[retired].dest, retired);
			compareField("value", got.value, progExpect[retired].value, retired);
			compareField("regWrite", got.regWrite, progExpect[retired].regWrite, retired);
			compareField("branchTaken", got.branchTaken, progExpect[retired].branchTaken, retired);
		end
		retired++;
	endtask

	// Producer sends while it holds a credit
	always @(posedge clk)
	begin
		if (!reset)
		begin
			instrValid <= 1'b0;
			if (producerCredits > 0 && sent < lineCount)
			begin
				instrValid <= 1'b1;
				instr <= progInstr[sent];
				sent++;
				producerCredits--; // Spent on this push
			end
		end
	end

	// Consumer returns credits when due, none during the opening hold
	always @(posedge clk)
	begin
		if (!reset)
		begin
			cycleCount++;
			retireCredit <= 1'b0;
			if (cycleCount > CreditHold && creditDue.size() > 0
				&& creditDue[0] <= cycleCount)
			begin
				retireCredit <= 1'b1;
				void'(creditDue.pop_front());
				outstanding--;
			end
		end
	end

	// Outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (reset === 1'b0)
		begin
			if (instrCredit)
			begin
				assert (producerCredits == 0)
				else
				begin
					$display("Instruction credit returned while the producer already held one");
					otherErrors++;
				end
				producerCredits++;
			end
			if (retireValid)
				checkRecord(retire);
		end
	end

	initial
	begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		retireCredit = 1'b0;
		lcgState = 32'h795a_e0d1;
		sent = 0;
		producerCredits = 1;
		retired = 0;
		outstanding = 0;
		cycleCount = 0;
		mismatches = 0;
		otherErrors = 0;
		loadProgram();
		cycleLimit = lineCount * 20 + 100; // Worst case with credit stalls
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		while (retired < lineCount && cycleCount < cycleLimit)
			@(negedge clk);
		repeat (20) @(negedge clk); // Late or duplicate records show up here
		assert (retired == lineCount && lineCount > 0)
		else
		begin
			$display("Run ended after %0d cycles with %0d of %0d instructions retired",
				cycleCount, retired, lineCount);
			otherErrors++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: dv/programStim.txt
// Columns in hex: instruction, dest, value, regWrite, branchTaken
// One line per instruction, expected retire records in program order
20011234 01 00001234 1 0
2002FFFD 02 FFFFFFFD 1 0
00221820 03 00001231 1 0
00222022 04 00001237 1 0
00222824 05 00001234 1 0
00223025 06 FFFFFFFD 1 0
0041382A 07 00000001 1 0
3C088765 08 87650000 1 0
35084321 08 87654321 1 0
3109FF00 09 00004300 1 0
284A0005 0A 00000001 1 0
AC080008 08 00000008 0 0
800B000B 0B FFFFFF87 1 0
900C000B 0C 00000087 1 0
840D000A 0D FFFF8765 1 0
940E000A 0E 00008765 1 0
8C0F0008 0F 87654321 1 0
9C100008 10 87654321 1 0
A0020009 02 00000009 0 0
A401000A 01 0000000A 0 0
8C110008 11 1234FD21 1 0
10210000 01 00000000 0 1
14220004 02 00001237 0 1
20000055 00 00000055 1 0
00019020 12 00001234 1 0

// File: sim.f
+incdir+include
logic/corePkg.sv
logic/controlUnit.sv
logic/cycleSequencer.sv
logic/creditCounter.sv
logic/registerFile.sv
logic/alu.sv
logic/dataMemory.sv
logic/mipsCore.sv
dv/mipsCore_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - logic/corePkg.sv
      - logic/controlUnit.sv
      - logic/cycleSequencer.sv
      - logic/creditCounter.sv
      - logic/registerFile.sv
      - logic/alu.sv
      - logic/dataMemory.sv
      - logic/mipsCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/mipsCore_tb.sv
